/* rtl/ecl_pkg.sv */
`default_nettype none

package ecl_pkg;

   //////////////////////////////
   // instruction fields
   //////////////////////////////

   localparam int REG_ADDR_W  = 5;
   localparam int INST_RD_LSB = 0;
   localparam int INST_RJ_LSB = 5;
   localparam int INST_RK_LSB = 10;

   // unit op code widths
   localparam int ALU_CODE_W = 5;
   localparam int LSU_CODE_W = 8;
   localparam int BRU_CODE_W = 4;

   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   //////////////////////////////
   // control bundles
   //////////////////////////////

   // decoded op as delivered by fetch
   typedef struct packed {
      logic                  lsu_related;
      logic                  bru_related;
      logic                  pc_related;
      logic                  rd_as_rj;
      logic                  rd_read;
      logic                  use_imm;
      logic                  double_read;
      logic                  double_word;
      logic [ALU_CODE_W-1:0] alu_code;
      logic [LSU_CODE_W-1:0] lsu_code;
      logic [BRU_CODE_W-1:0] bru_code;
   } dec_op_t;

   // register file write heading for w
   typedef struct packed {
      reg_addr_t rd;
      logic      wen;
   } wb_ctl_t;

   typedef struct packed {
      logic                  valid;
      logic [LSU_CODE_W-1:0] op;
      reg_addr_t             rd;
      logic                  wen;
   } lsu_ctl_t;

   typedef struct packed {
      logic                  valid;
      logic [BRU_CODE_W-1:0] op;
   } bru_ctl_t;

   // sources and mux hints for the e-stage forwarding
   typedef struct packed {
      reg_addr_t rs1;
      reg_addr_t rs2;
      logic      a_use_other;
      logic      b_use_other;
      logic      double_read;
   } byp_ctl_t;

endpackage

`default_nettype wire

/* rtl/ecl_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ecl_stage_reg #(
   parameter type payload_t = logic
) (
   input  wire          clk,
   input  wire          rst,
   input  var payload_t d,
   output payload_t     q
);

   // one pipeline crossing, cleared to an idle payload
   always_ff @(posedge clk) begin
      if (rst) begin
         q <= '0;
      end else begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

/* rtl/ecl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ecl_decode
   import ecl_pkg::*;
#(
   parameter int GRLEN = 32
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   valid_d,
   input  wire [31:0]            inst_d,
   input  wire [GRLEN-1:0]       pc_d,
   input  wire [GRLEN-1:0]       imm_d,
   input  wire [GRLEN-1:0]       br_offs_d,
   input  wire [GRLEN-1:0]       rs1_data_d,
   input  wire [GRLEN-1:0]       rs2_data_d,
   input  var dec_op_t           op_d,
   input  wire                   rf_wen_d,
   input  var reg_addr_t         rf_target_d,
   input  wire                   br_taken_e,
   input  wire                   lsu_finish_m,
   output reg_addr_t             rs1_d,
   output reg_addr_t             rs2_d,
   output byp_ctl_t              byp_e,
   output logic [GRLEN-1:0]      a_base_e,
   output logic [GRLEN-1:0]      b_base_e,
   output logic [GRLEN-1:0]      imm_e,
   output logic [GRLEN-1:0]      bru_pc_e,
   output logic [GRLEN-1:0]      bru_offs_e,
   output logic [ALU_CODE_W-1:0] alu_op_e,
   output logic                  alu_double_word_e,
   output lsu_ctl_t              lsu_e,
   output bru_ctl_t              bru_e,
   output wb_ctl_t               alu_wb_e,
   output logic                  exu_br_taken_e,
   output logic                  stall_req
);

   logic                kill_d;
   logic                inst_vld_d;
   logic                alu_dispatch_d;
   logic                lsu_dispatch_d;
   logic                bru_dispatch_d;
   logic                b_imm_d;
   logic [GRLEN-1:0]    a_base_d;
   logic [GRLEN-1:0]    b_base_d;
   logic [ALU_CODE_W:0] alu_ctl_d;
   logic [ALU_CODE_W:0] alu_ctl_e;
   byp_ctl_t            byp_d;
   lsu_ctl_t            lsu_d;
   bru_ctl_t            bru_d;
   wb_ctl_t             alu_wb_d;
   logic                lsu_stall_q;
   logic                lsu_stall_next;

   //////////////////////////////
   // kill and dispatch
   //////////////////////////////

   // taken branch in e squashes the instruction behind it
   assign kill_d         = bru_e.valid & br_taken_e;
   assign exu_br_taken_e = kill_d;
   assign inst_vld_d     = valid_d & ~kill_d;

   assign lsu_dispatch_d = op_d.lsu_related & inst_vld_d;
   assign bru_dispatch_d = op_d.bru_related & inst_vld_d;
   assign alu_dispatch_d = ~op_d.lsu_related & ~op_d.bru_related & inst_vld_d;

   // register file read ports
   assign rs1_d = op_d.rd_as_rj ? inst_d[INST_RD_LSB +: REG_ADDR_W]
                                : inst_d[INST_RJ_LSB +: REG_ADDR_W];
   assign rs2_d = op_d.rd_read  ? inst_d[INST_RD_LSB +: REG_ADDR_W]
                                : inst_d[INST_RK_LSB +: REG_ADDR_W];

   // immediate only replaces b for alu ops
   assign b_imm_d  = op_d.use_imm & alu_dispatch_d;
   assign a_base_d = op_d.pc_related ? pc_d : rs1_data_d;
   assign b_base_d = b_imm_d ? imm_d : rs2_data_d;

   assign byp_d = '{rs1:         rs1_d,
                    rs2:         rs2_d,
                    a_use_other: op_d.pc_related,
                    b_use_other: b_imm_d | (op_d.double_read & lsu_dispatch_d),
                    double_read: op_d.double_read & lsu_dispatch_d};

   assign lsu_d    = '{valid: lsu_dispatch_d, op: op_d.lsu_code,
                       rd: rf_target_d, wen: rf_wen_d & lsu_dispatch_d};
   assign bru_d    = '{valid: bru_dispatch_d, op: op_d.bru_code};
   // rd rides along for branch link writes too
   assign alu_wb_d = '{rd: rf_target_d, wen: rf_wen_d & alu_dispatch_d};

   assign alu_ctl_d = {op_d.double_word, op_d.alu_code};
   assign {alu_double_word_e, alu_op_e} = alu_ctl_e;

   //////////////////////////////
   // d to e
   //////////////////////////////

   ecl_stage_reg #(.payload_t(byp_ctl_t)) byp_d2e_reg (
      .clk, .rst, .d(byp_d), .q(byp_e));
   ecl_stage_reg #(.payload_t(logic [GRLEN-1:0])) a_base_d2e_reg (
      .clk, .rst, .d(a_base_d), .q(a_base_e));
   ecl_stage_reg #(.payload_t(logic [GRLEN-1:0])) b_base_d2e_reg (
      .clk, .rst, .d(b_base_d), .q(b_base_e));
   ecl_stage_reg #(.payload_t(logic [GRLEN-1:0])) imm_d2e_reg (
      .clk, .rst, .d(imm_d), .q(imm_e));
   ecl_stage_reg #(.payload_t(logic [GRLEN-1:0])) bru_pc_d2e_reg (
      .clk, .rst, .d(pc_d), .q(bru_pc_e));
   ecl_stage_reg #(.payload_t(logic [GRLEN-1:0])) bru_offs_d2e_reg (
      .clk, .rst, .d(br_offs_d), .q(bru_offs_e));
   ecl_stage_reg #(.payload_t(logic [ALU_CODE_W:0])) alu_ctl_d2e_reg (
      .clk, .rst, .d(alu_ctl_d), .q(alu_ctl_e));
   ecl_stage_reg #(.payload_t(lsu_ctl_t)) lsu_d2e_reg (
      .clk, .rst, .d(lsu_d), .q(lsu_e));
   ecl_stage_reg #(.payload_t(bru_ctl_t)) bru_d2e_reg (
      .clk, .rst, .d(bru_d), .q(bru_e));
   ecl_stage_reg #(.payload_t(wb_ctl_t)) alu_wb_d2e_reg (
      .clk, .rst, .d(alu_wb_d), .q(alu_wb_e));

   // load/store keeps fetch informed until the unit is done
   assign lsu_stall_next = lsu_dispatch_d | (lsu_stall_q & ~lsu_finish_m);
   assign stall_req      = lsu_stall_next;

   ecl_stage_reg #(.payload_t(logic)) lsu_stall_reg (
      .clk, .rst, .d(lsu_stall_next), .q(lsu_stall_q));

   assert property (@(posedge clk) disable iff (rst)
      $onehot0({alu_dispatch_d, lsu_dispatch_d, bru_dispatch_d}));

endmodule

`default_nettype wire

/* rtl/ecl_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

module ecl_bypass
   import ecl_pkg::*;
#(
   parameter int GRLEN = 32
) (
   input  var byp_ctl_t     byp_e,
   input  wire [GRLEN-1:0]  a_base_e,
   input  wire [GRLEN-1:0]  b_base_e,
   input  wire [GRLEN-1:0]  imm_e,
   input  var reg_addr_t    rd_m,
   input  var reg_addr_t    rd_w,
   input  wire              wen_m,
   input  wire              wen_w,
   input  wire [GRLEN-1:0]  rd_data_m,
   input  wire [GRLEN-1:0]  rd_data_w,
   output logic [GRLEN-1:0] alu_a_e,
   output logic [GRLEN-1:0] alu_b_e,
   output logic [GRLEN-1:0] lsu_offset_e
);

   // select bits are {base, m, w}
   logic [2:0] a_sel;
   logic [2:0] b_sel;

   //////////////////////////////
   // forwarding select
   //////////////////////////////

   // m is younger and wins over w
   function automatic logic [2:0] fwd_sel(reg_addr_t rs, logic use_other);
      logic can_fwd;
      logic hit_m;
      logic hit_w;
      can_fwd = (rs != '0) && !use_other;
      hit_m   = can_fwd && wen_m && (rs == rd_m);
      hit_w   = can_fwd && wen_w && (rs == rd_w) && !hit_m;
      return {!hit_m && !hit_w, hit_m, hit_w};
   endfunction

   // and-or mux
   function automatic logic [GRLEN-1:0] fwd_mux(logic [2:0] sel, logic [GRLEN-1:0] base);
      return ({GRLEN{sel[2]}} & base)
           | ({GRLEN{sel[1]}} & rd_data_m)
           | ({GRLEN{sel[0]}} & rd_data_w);
   endfunction

   always_comb begin
      a_sel = fwd_sel(byp_e.rs1, byp_e.a_use_other);
      b_sel = fwd_sel(byp_e.rs2, byp_e.b_use_other);
   end

   //////////////////////////////
   // operands
   //////////////////////////////

   always_comb begin
      alu_a_e = fwd_mux(a_sel, a_base_e);
      alu_b_e = fwd_mux(b_sel, b_base_e);
   end

   // register offset for indexed access, immediate otherwise
   assign lsu_offset_e = byp_e.double_read ? alu_b_e : imm_e;

endmodule

`default_nettype wire

/* rtl/ecl_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module ecl_writeback
   import ecl_pkg::*;
#(
   parameter int GRLEN = 32
) (
   input  wire              clk,
   input  wire              rst,
   input  var wb_ctl_t      alu_wb_e,
   input  wire [GRLEN-1:0]  alu_res_e,
   input  wire [GRLEN-1:0]  bru_link_pc_e,
   input  wire              bru_wen_e,
   input  wire              lsu_finish_m,
   input  var reg_addr_t    lsu_rd_m,
   input  wire              lsu_wen_m,
   input  wire [GRLEN-1:0]  lsu_rdata_m,
   output reg_addr_t        rd_m,
   output reg_addr_t        rd_w,
   output logic             wen_m,
   output logic             wen_w,
   output logic [GRLEN-1:0] rd_data_m,
   output logic [GRLEN-1:0] rd_data_w
);

   wb_ctl_t          alu_wb_m;
   logic [GRLEN-1:0] alu_res_m;
   logic [GRLEN-1:0] bru_link_pc_m;
   logic             bru_wen_m;
   wb_ctl_t          wb_m;
   wb_ctl_t          wb_w;

   //////////////////////////////
   // e to m
   //////////////////////////////

   ecl_stage_reg #(.payload_t(wb_ctl_t)) alu_wb_e2m_reg (
      .clk, .rst, .d(alu_wb_e), .q(alu_wb_m));
   ecl_stage_reg #(.payload_t(logic [GRLEN-1:0])) alu_res_e2m_reg (
      .clk, .rst, .d(alu_res_e), .q(alu_res_m));
   ecl_stage_reg #(.payload_t(logic [GRLEN-1:0])) bru_link_pc_e2m_reg (
      .clk, .rst, .d(bru_link_pc_e), .q(bru_link_pc_m));
   ecl_stage_reg #(.payload_t(logic)) bru_wen_e2m_reg (
      .clk, .rst, .d(bru_wen_e), .q(bru_wen_m));

   //////////////////////////////
   // m-stage select
   //////////////////////////////

   // lsu tracks its own rd, branch shares the alu one
   assign rd_m  = lsu_finish_m ? lsu_rd_m : alu_wb_m.rd;
   assign wen_m = alu_wb_m.wen | bru_wen_m | (lsu_wen_m & lsu_finish_m);

   // alu result unless another unit claims the slot
   assign rd_data_m = lsu_finish_m ? lsu_rdata_m
                    : bru_wen_m    ? bru_link_pc_m
                    :                alu_res_m;

   assign wb_m = '{rd: rd_m, wen: wen_m};

   //////////////////////////////
   // m to w
   //////////////////////////////

   ecl_stage_reg #(.payload_t(wb_ctl_t)) wb_m2w_reg (
      .clk, .rst, .d(wb_m), .q(wb_w));
   ecl_stage_reg #(.payload_t(logic [GRLEN-1:0])) rd_data_m2w_reg (
      .clk, .rst, .d(rd_data_m), .q(rd_data_w));

   assign rd_w  = wb_w.rd;
   assign wen_w = wb_w.wen;

   // a write must land on a real register index
   assert property (@(posedge clk) disable iff (rst)
      wen_w |-> !$isunknown(rd_w));

endmodule

`default_nettype wire

/* rtl/exu_ecl.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_ecl
   import ecl_pkg::*;
#(
   parameter int GRLEN = 32
) (
   input  wire                   clk,
   input  wire                   rst,
   // decode stage
   input  wire                   valid_d,
   input  wire [31:0]            inst_d,
   input  wire [GRLEN-1:0]       pc_d,
   input  wire [GRLEN-1:0]       imm_d,
   input  wire [GRLEN-1:0]       br_offs_d,
   input  wire [GRLEN-1:0]       rs1_data_d,
   input  wire [GRLEN-1:0]       rs2_data_d,
   input  var dec_op_t           op_d,
   input  wire                   rf_wen_d,
   input  var reg_addr_t         rf_target_d,
   output reg_addr_t             rs1_d,
   output reg_addr_t             rs2_d,
   // alu
   output logic [GRLEN-1:0]      alu_a_e,
   output logic [GRLEN-1:0]      alu_b_e,
   output logic [ALU_CODE_W-1:0] alu_op_e,
   output logic                  alu_double_word_e,
   input  wire [GRLEN-1:0]       alu_res_e,
   // lsu
   output lsu_ctl_t              lsu_e,
   output logic [GRLEN-1:0]      lsu_base_e,
   output logic [GRLEN-1:0]      lsu_offset_e,
   output logic [GRLEN-1:0]      lsu_wdata_e,
   input  wire                   lsu_finish_m,
   input  var reg_addr_t         lsu_rd_m,
   input  wire                   lsu_wen_m,
   input  wire [GRLEN-1:0]       lsu_rdata_m,
   // bru
   output bru_ctl_t              bru_e,
   output logic [GRLEN-1:0]      bru_a_e,
   output logic [GRLEN-1:0]      bru_b_e,
   output logic [GRLEN-1:0]      bru_pc_e,
   output logic [GRLEN-1:0]      bru_offs_e,
   input  wire                   br_taken_e,
   input  wire [GRLEN-1:0]       bru_link_pc_e,
   input  wire                   bru_wen_e,
   // fetch feedback
   output logic                  exu_ifu_br_taken_e,
   output logic                  exu_ifu_stall_req,
   // register file write
   output reg_addr_t             irf_rd_w,
   output logic                  irf_wen_w,
   output logic [GRLEN-1:0]      irf_rd_data_w
);

   byp_ctl_t         byp_e;
   logic [GRLEN-1:0] a_base_e;
   logic [GRLEN-1:0] b_base_e;
   logic [GRLEN-1:0] imm_e;
   wb_ctl_t          alu_wb_e;
   reg_addr_t        rd_m;
   logic             wen_m;
   logic [GRLEN-1:0] rd_data_m;

   ecl_decode #(.GRLEN(GRLEN)) decode_stage (
      .clk, .rst, .valid_d, .inst_d, .pc_d, .imm_d, .br_offs_d,
      .rs1_data_d, .rs2_data_d, .op_d, .rf_wen_d, .rf_target_d,
      .br_taken_e, .lsu_finish_m,
      .rs1_d, .rs2_d, .byp_e, .a_base_e, .b_base_e, .imm_e,
      .bru_pc_e, .bru_offs_e, .alu_op_e, .alu_double_word_e,
      .lsu_e, .bru_e, .alu_wb_e,
      .exu_br_taken_e (exu_ifu_br_taken_e),
      .stall_req      (exu_ifu_stall_req));

   ecl_bypass #(.GRLEN(GRLEN)) bypass_unit (
      .byp_e, .a_base_e, .b_base_e, .imm_e,
      .rd_m, .wen_m, .rd_data_m,
      .rd_w      (irf_rd_w),
      .wen_w     (irf_wen_w),
      .rd_data_w (irf_rd_data_w),
      .alu_a_e, .alu_b_e, .lsu_offset_e);

   ecl_writeback #(.GRLEN(GRLEN)) wb_unit (
      .clk, .rst, .alu_wb_e, .alu_res_e, .bru_link_pc_e, .bru_wen_e,
      .lsu_finish_m, .lsu_rd_m, .lsu_wen_m, .lsu_rdata_m,
      .rd_m, .wen_m, .rd_data_m,
      .rd_w      (irf_rd_w),
      .wen_w     (irf_wen_w),
      .rd_data_w (irf_rd_data_w));

   // forwarded operands fan out to lsu and bru
   assign lsu_base_e  = alu_a_e;
   assign lsu_wdata_e = alu_b_e;
   assign bru_a_e     = alu_a_e;
   assign bru_b_e     = alu_b_e;

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter real PERIOD_NS = 4.0
) (
   output logic clk
);

   initial clk = 1'b0;

   // free running, low first
   always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

/* verification/tb_exu_ecl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exu_ecl
   import ecl_pkg::*;
();

   localparam int GRLEN       = 32;
   localparam int N_ROWS      = 11;
   localparam int N_STREAM    = 9;
   localparam int LSU_TIMEOUT = 16;
   localparam logic [1:0] K_ALU = 2'd0;
   localparam logic [1:0] K_BRU = 2'd1;
   localparam logic [1:0] K_LSU = 2'd2;

   // flags are {pc_related, use_imm, double_read}
   typedef struct packed {
      logic [1:0]       kind;
      logic [2:0]       flags;
      reg_addr_t        rj;
      reg_addr_t        rk;
      logic [GRLEN-1:0] pc;
      logic [GRLEN-1:0] imm;
      reg_addr_t        target;
      logic             wen;
      logic             taken;
      logic             bru_wen;
      logic [GRLEN-1:0] res;
      logic [3:0]       lat;
      logic             exp_wen;
      reg_addr_t        exp_rd;
      logic [GRLEN-1:0] exp_data;
      logic [GRLEN-1:0] rs1_data;
      logic [GRLEN-1:0] rs2_data;
   } row_t;

   logic                  clk;
   logic                  rst;
   logic                  valid_d;
   logic [31:0]           inst_d;
   logic [GRLEN-1:0]      pc_d;
   logic [GRLEN-1:0]      imm_d;
   logic [GRLEN-1:0]      br_offs_d;
   logic [GRLEN-1:0]      rs1_data_d;
   logic [GRLEN-1:0]      rs2_data_d;
   dec_op_t               op_d;
   logic                  rf_wen_d;
   reg_addr_t             rf_target_d;
   reg_addr_t             rs1_d;
   reg_addr_t             rs2_d;
   logic [GRLEN-1:0]      alu_a_e;
   logic [GRLEN-1:0]      alu_b_e;
   logic [ALU_CODE_W-1:0] alu_op_e;
   logic                  alu_double_word_e;
   logic [GRLEN-1:0]      alu_res_e;
   lsu_ctl_t              lsu_e;
   logic [GRLEN-1:0]      lsu_base_e;
   logic [GRLEN-1:0]      lsu_offset_e;
   logic [GRLEN-1:0]      lsu_wdata_e;
   logic                  lsu_finish_m;
   reg_addr_t             lsu_rd_m;
   logic                  lsu_wen_m;
   logic [GRLEN-1:0]      lsu_rdata_m;
   bru_ctl_t              bru_e;
   logic [GRLEN-1:0]      bru_a_e;
   logic [GRLEN-1:0]      bru_b_e;
   logic [GRLEN-1:0]      bru_pc_e;
   logic [GRLEN-1:0]      bru_offs_e;
   logic                  br_taken_e;
   logic [GRLEN-1:0]      bru_link_pc_e;
   logic                  bru_wen_e;
   logic                  exu_ifu_br_taken_e;
   logic                  exu_ifu_stall_req;
   reg_addr_t             irf_rd_w;
   logic                  irf_wen_w;
   logic [GRLEN-1:0]      irf_rd_data_w;

   row_t   tbl [N_ROWS];
   logic   killed [N_ROWS];
   int     row_err [N_ROWS];
   int     errors;
   integer seed;

   tb_clock_gen #(.PERIOD_NS(4.0)) clock_gen (.clk);

   exu_ecl #(.GRLEN(GRLEN)) i_dut (.*);

   //////////////////////////////
   // stimulus table
   //////////////////////////////

   function automatic row_t make_row(
      input logic [1:0] kind, input logic [2:0] flags, input reg_addr_t rj,
      input reg_addr_t rk, input logic [GRLEN-1:0] pc, input logic [GRLEN-1:0] imm,
      input reg_addr_t target, input logic wen, input logic taken, input logic bru_wen,
      input logic [GRLEN-1:0] res, input logic [3:0] lat, input logic exp_wen,
      input reg_addr_t exp_rd, input logic [GRLEN-1:0] exp_data);
      return {kind, flags, rj, rk, pc, imm, target, wen, taken, bru_wen, res, lat,
              exp_wen, exp_rd, exp_data, {2*GRLEN{1'b0}}};
   endfunction

   task automatic fill_table();
      // kind flags rj rk pc imm target wen taken bru_wen res lat | exp wen rd data
      tbl[0]  = make_row(K_ALU, 3'b000, 5'd1, 5'd2, 32'h0, 32'h0, 5'd3, 1, 0, 0,
                         32'h1111_0003, 4'd0, 1, 5'd3, 32'h1111_0003);
      tbl[1]  = make_row(K_ALU, 3'b000, 5'd3, 5'd0, 32'h0, 32'h0, 5'd4, 1, 0, 0,
                         32'h2222_0004, 4'd0, 1, 5'd4, 32'h2222_0004);
      tbl[2]  = make_row(K_ALU, 3'b000, 5'd3, 5'd4, 32'h0, 32'h0, 5'd5, 1, 0, 0,
                         32'h3333_0005, 4'd0, 1, 5'd5, 32'h3333_0005);
      tbl[3]  = make_row(K_ALU, 3'b110, 5'd5, 5'd5, 32'h1000, 32'h40, 5'd0, 1, 0, 0,
                         32'h4444_0000, 4'd0, 1, 5'd0, 32'h4444_0000);
      tbl[4]  = make_row(K_ALU, 3'b000, 5'd0, 5'd0, 32'h0, 32'h0, 5'd7, 1, 0, 0,
                         32'h5555_0007, 4'd0, 1, 5'd7, 32'h5555_0007);
      tbl[5]  = make_row(K_BRU, 3'b000, 5'd7, 5'd0, 32'h2000, 32'h80, 5'd1, 1, 1, 1,
                         32'h0000_2004, 4'd0, 1, 5'd1, 32'h0000_2004);
      // squashed by the taken branch ahead of it
      tbl[6]  = make_row(K_ALU, 3'b000, 5'd1, 5'd0, 32'h0, 32'h0, 5'd8, 1, 0, 0,
                         32'h6666_0008, 4'd0, 0, 5'd0, 32'h0);
      tbl[7]  = make_row(K_BRU, 3'b000, 5'd1, 5'd0, 32'h3000, 32'h10, 5'd0, 0, 0, 0,
                         32'h0, 4'd0, 0, 5'd0, 32'h0);
      tbl[8]  = make_row(K_ALU, 3'b000, 5'd1, 5'd8, 32'h0, 32'h0, 5'd9, 1, 0, 0,
                         32'h7777_0009, 4'd0, 1, 5'd9, 32'h7777_0009);
      tbl[9]  = make_row(K_LSU, 3'b000, 5'd9, 5'd2, 32'h0, 32'h10, 5'd10, 1, 0, 0,
                         32'h8888_000a, 4'd3, 1, 5'd10, 32'h8888_000a);
      tbl[10] = make_row(K_LSU, 3'b001, 5'd2, 5'd3, 32'h0, 32'h20, 5'd0, 0, 0, 0,
                         32'h0, 4'd1, 0, 5'd0, 32'h0);
   endtask

   function automatic string kind_name(input logic [1:0] kind);
      case (kind)
         K_ALU:   return "alu";
         K_BRU:   return "branch";
         default: return "load/store";
      endcase
   endfunction

   // m holds row j-1 and w holds row j-2 while row j sits in e
   function automatic logic [GRLEN-1:0] fwd_value(input int j, input reg_addr_t rs,
                                                  input logic [GRLEN-1:0] base);
      if (rs != 0 && j >= 1 && tbl[j-1].exp_wen && tbl[j-1].exp_rd == rs)
         return tbl[j-1].exp_data;
      if (rs != 0 && j >= 2 && tbl[j-2].exp_wen && tbl[j-2].exp_rd == rs)
         return tbl[j-2].exp_data;
      return base;
   endfunction

   //////////////////////////////
   // drivers
   //////////////////////////////

   task automatic drive_idle();
      valid_d     = 1'b0;
      inst_d      = '0;
      pc_d        = '0;
      imm_d       = '0;
      br_offs_d   = '0;
      rs1_data_d  = '0;
      rs2_data_d  = '0;
      op_d        = '0;
      rf_wen_d    = 1'b0;
      rf_target_d = '0;
   endtask

   task automatic drive_d(input int j);
      row_t r;
      r                = tbl[j];
      valid_d          = 1'b1;
      inst_d           = {17'b0, r.rk, r.rj, 5'b0};
      pc_d             = r.pc;
      imm_d            = r.imm;
      br_offs_d        = r.imm;
      rs1_data_d       = r.rs1_data;
      rs2_data_d       = r.rs2_data;
      op_d             = '0;
      op_d.lsu_related = (r.kind == K_LSU);
      op_d.bru_related = (r.kind == K_BRU);
      op_d.pc_related  = r.flags[2];
      op_d.use_imm     = r.flags[1];
      op_d.double_read = r.flags[0];
      // unit op codes tagged with the row index
      op_d.double_word = j[0];
      op_d.alu_code    = ALU_CODE_W'(j + 1);
      op_d.lsu_code    = LSU_CODE_W'(j);
      op_d.bru_code    = BRU_CODE_W'(j);
      rf_wen_d         = r.wen;
      rf_target_d      = r.target;
   endtask

   task automatic clear_resp();
      alu_res_e     = '0;
      bru_link_pc_e = '0;
      br_taken_e    = 1'b0;
      bru_wen_e     = 1'b0;
      lsu_finish_m  = 1'b0;
      lsu_rd_m      = '0;
      lsu_wen_m     = 1'b0;
      lsu_rdata_m   = '0;
   endtask

   // unit responses for the row sitting in e
   task automatic drive_resp(input int j);
      alu_res_e     = tbl[j].res;
      bru_link_pc_e = tbl[j].res;
      br_taken_e    = tbl[j].taken;
      bru_wen_e     = tbl[j].bru_wen;
   endtask

   //////////////////////////////
   // checks
   //////////////////////////////

   task automatic report_mismatch(input int j, input string what,
                                  input logic [GRLEN-1:0] got, input logic [GRLEN-1:0] exp);
      $display("mismatch at %0t: row %0d %s got %h expected %h", $time, j, what, got, exp);
      errors++;
      row_err[j]++;
   endtask

   // register file read indices at d
   task automatic check_d(input int j);
      if (rs1_d !== tbl[j].rj)
         report_mismatch(j, "rs1_d", rs1_d, tbl[j].rj);
      if (rs2_d !== tbl[j].rk)
         report_mismatch(j, "rs2_d", rs2_d, tbl[j].rk);
   endtask

   task automatic check_e(input int j);
      row_t             r;
      logic             exp_bru;
      logic             exp_alu;
      logic [GRLEN-1:0] exp_a;
      logic [GRLEN-1:0] exp_b;
      r       = tbl[j];
      exp_bru = (r.kind == K_BRU) && !killed[j];
      exp_alu = (r.kind == K_ALU) && !killed[j];
      exp_a   = r.flags[2] ? r.pc : fwd_value(j, r.rj, r.rs1_data);
      exp_b   = r.flags[1] ? r.imm : fwd_value(j, r.rk, r.rs2_data);
      if (bru_e.valid !== exp_bru)
         report_mismatch(j, "bru valid", bru_e.valid, exp_bru);
      if (exp_bru && bru_e.op !== BRU_CODE_W'(j))
         report_mismatch(j, "bru op", bru_e.op, BRU_CODE_W'(j));
      if (lsu_e.valid !== 1'b0)
         report_mismatch(j, "lsu valid", lsu_e.valid, 1'b0);
      if (exu_ifu_br_taken_e !== (exp_bru & r.taken))
         report_mismatch(j, "br_taken", exu_ifu_br_taken_e, exp_bru & r.taken);
      if (exu_ifu_stall_req !== 1'b0)
         report_mismatch(j, "stall request", exu_ifu_stall_req, 1'b0);
      if (!killed[j] && alu_a_e !== exp_a)
         report_mismatch(j, "alu_a_e", alu_a_e, exp_a);
      if (!killed[j] && alu_b_e !== exp_b)
         report_mismatch(j, "alu_b_e", alu_b_e, exp_b);
      if (!killed[j] && bru_a_e !== exp_a)
         report_mismatch(j, "bru_a_e", bru_a_e, exp_a);
      if (!killed[j] && bru_b_e !== exp_b)
         report_mismatch(j, "bru_b_e", bru_b_e, exp_b);
      if (!killed[j] && bru_pc_e !== r.pc)
         report_mismatch(j, "bru_pc_e", bru_pc_e, r.pc);
      if (!killed[j] && bru_offs_e !== r.imm)
         report_mismatch(j, "bru_offs_e", bru_offs_e, r.imm);
      if (exp_alu && alu_op_e !== ALU_CODE_W'(j + 1))
         report_mismatch(j, "alu_op_e", alu_op_e, ALU_CODE_W'(j + 1));
      if (exp_alu && alu_double_word_e !== j[0])
         report_mismatch(j, "alu_double_word_e", alu_double_word_e, j[0]);
   endtask

   // last look at a row, so its result line goes out here
   task automatic check_w(input int j);
      row_t r;
      r = tbl[j];
      if (irf_wen_w !== r.exp_wen)
         report_mismatch(j, "irf_wen_w", irf_wen_w, r.exp_wen);
      if (r.exp_wen && irf_rd_w !== r.exp_rd)
         report_mismatch(j, "irf_rd_w", irf_rd_w, r.exp_rd);
      if (r.exp_wen && irf_rd_data_w !== r.exp_data)
         report_mismatch(j, "irf_rd_data_w", irf_rd_data_w, r.exp_data);
      $display("row %0d %s: %s", j, kind_name(r.kind), row_err[j] == 0 ? "pass" : "fail");
   endtask

   task automatic run_lsu(input int j);
      row_t r;
      int   cnt;
      r = tbl[j];
      // idle cycles so m and w hold nothing to forward
      repeat (2) begin
         @(posedge clk);
         #1;
         drive_idle();
         clear_resp();
      end
      @(posedge clk);
      #1;
      drive_d(j);
      #2;
      check_d(j);
      if (exu_ifu_stall_req !== 1'b1)
         report_mismatch(j, "stall at dispatch", exu_ifu_stall_req, 1'b1);
      @(posedge clk);
      #1;
      drive_idle();
      #2;
      if (lsu_e.valid !== 1'b1)
         report_mismatch(j, "lsu valid", lsu_e.valid, 1'b1);
      if (lsu_e.op !== LSU_CODE_W'(j))
         report_mismatch(j, "lsu op", lsu_e.op, LSU_CODE_W'(j));
      if (lsu_e.rd !== r.target)
         report_mismatch(j, "lsu rd", lsu_e.rd, r.target);
      if (lsu_e.wen !== r.wen)
         report_mismatch(j, "lsu wen", lsu_e.wen, r.wen);
      if (lsu_base_e !== r.rs1_data)
         report_mismatch(j, "lsu_base_e", lsu_base_e, r.rs1_data);
      if (lsu_offset_e !== (r.flags[0] ? r.rs2_data : r.imm))
         report_mismatch(j, "lsu_offset_e", lsu_offset_e, r.flags[0] ? r.rs2_data : r.imm);
      if (lsu_wdata_e !== r.rs2_data)
         report_mismatch(j, "lsu_wdata_e", lsu_wdata_e, r.rs2_data);
      if (exu_ifu_stall_req !== 1'b1)
         report_mismatch(j, "stall in e", exu_ifu_stall_req, 1'b1);
      cnt = 0;
      do begin
         @(posedge clk);
         #1;
         cnt++;
         lsu_finish_m = (cnt == r.lat);
         lsu_rd_m     = r.target;
         lsu_wen_m    = r.wen;
         lsu_rdata_m  = r.res;
         #2;
         if (exu_ifu_stall_req !== (cnt < r.lat))
            report_mismatch(j, "stall request", exu_ifu_stall_req, cnt < r.lat);
      end while (exu_ifu_stall_req === 1'b1 && cnt < LSU_TIMEOUT);
      if (exu_ifu_stall_req !== 1'b0) begin
         $display("timeout: stall request of row %0d never dropped", j);
         errors++;
         row_err[j]++;
      end
      @(posedge clk);
      #1;
      clear_resp();
      #2;
      check_w(j);
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      int k;
      int j;
      int passed;
      seed   = 32'h190c;
      errors = 0;
      passed = 0;
      rst    = 1'b1;
      drive_idle();
      clear_resp();
      fill_table();
      for (j = 0; j < N_ROWS; j++) begin
         tbl[j].rs1_data = $random(seed);
         tbl[j].rs2_data = $random(seed);
         killed[j]  = (j > 0) && tbl[j-1].kind == K_BRU && tbl[j-1].taken && !killed[j-1];
         row_err[j] = 0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      // one row per cycle, e checked one cycle later, w three cycles later
      for (k = 0; k < N_STREAM + 3; k++) begin
         @(posedge clk);
         #1;
         if (k < N_STREAM) begin
            drive_d(k);
         end else begin
            drive_idle();
         end
         if (k >= 1 && k - 1 < N_STREAM) begin
            drive_resp(k - 1);
         end else begin
            clear_resp();
         end
         #2;
         if (k < N_STREAM)
            check_d(k);
         if (k >= 1 && k - 1 < N_STREAM)
            check_e(k - 1);
         if (k >= 3)
            check_w(k - 3);
      end

      for (j = N_STREAM; j < N_ROWS; j++)
         run_lsu(j);

      for (j = 0; j < N_ROWS; j++) begin
         if (row_err[j] == 0)
            passed++;
      end
      $display("rows %0d, passed %0d, failed %0d, check errors %0d",
               N_ROWS, passed, N_ROWS - passed, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* exu_ecl.f */
rtl/ecl_pkg.sv
rtl/ecl_stage_reg.sv
rtl/ecl_decode.sv
rtl/ecl_bypass.sv
rtl/ecl_writeback.sv
rtl/exu_ecl.sv
verification/tb_clock_gen.sv
verification/tb_exu_ecl.sv

/* Bender.yml */
package:
  name: exu_ecl

sources:
  - files:
      - rtl/ecl_pkg.sv
      - rtl/ecl_stage_reg.sv
      - rtl/ecl_decode.sv
      - rtl/ecl_bypass.sv
      - rtl/ecl_writeback.sv
      - rtl/exu_ecl.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_exu_ecl.sv
